// File: serial_rf.f
+incdir+rtl
rtl/serial_rf_pkg.sv
rtl/rf_ram.sv
rtl/rf_write_sched.sv
rtl/rf_read_sched.sv
rtl/serial_rf.sv
testbench/tb_serial_rf.sv

// File: Makefile
TB_TOP := tb_serial_rf

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f serial_rf.f --top-module serial_rf

sim:
	verilator --binary --timing --assert -f serial_rf.f --top-module $(TB_TOP) -o sim_$(TB_TOP)
	@out="$$(./obj_dir/sim_$(TB_TOP))"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

// File: testbench/tb_serial_rf.sv
`timescale 1ns/100ps
`default_nettype none

`include "serial_rf_cfg.svh"

module tb_serial_rf;

   localparam int NROWS      = 47;
   localparam int RST_CYCLES = 16;

   localparam logic [1:0] OP_WR   = 2'd0;
   localparam logic [1:0] OP_LATE = 2'd1;
   localparam logic [1:0] OP_RD   = 2'd2;
   localparam logic [1:0] VS_LFSR = 2'd0;
   localparam logic [1:0] VS_ONES = 2'd1;
   localparam logic [1:0] VS_ZERO = 2'd2;

   // mask is {rd, csr, mepc, mtval}, vsrc picks the written word
   typedef struct packed {
      logic [1:0] op;
      logic [3:0] mask;
      logic [4:0] rd;
      logic [4:0] alt;
      logic [4:0] rs1;
      logic [4:0] rs2;
      logic [1:0] sel;
      logic       csr_en;
      logic [1:0] vsrc;
   } row_t;

   logic       i_clk;
   logic       i_rst;
   logic       i_rd_wen;
   logic [4:0] i_rd_waddr;
   logic       i_rd;
   logic       i_csr_en;
   logic [1:0] i_csr_sel;
   logic       i_csr;
   logic       o_csr;
   logic       i_mepc_wen;
   logic       i_mepc;
   logic       i_mtval_wen;
   logic       i_mtval;
   logic       i_rreq;
   logic       o_rgnt;
   logic [4:0] i_rs1_raddr;
   logic       o_rs1;
   logic [4:0] i_rs2_raddr;
   logic       o_rs2;

   row_t        rows [0:NROWS-1];
   int          nrows;
   logic [31:0] gpr [0:31];
   logic [31:0] csr [0:3];
   logic [31:0] gpr_seen;
   logic [4:0]  wr_list [$];
   logic [31:0] lfsr_q;
   logic [31:0] got_rs1;
   logic [31:0] got_rs2;
   logic [31:0] got_csr;
   int          r;

   serial_rf dut0 (
      .i_clk (i_clk), .i_rst (i_rst),
      .i_rd_wen (i_rd_wen), .i_rd_waddr (i_rd_waddr), .i_rd (i_rd),
      .i_csr_en (i_csr_en), .i_csr_sel (i_csr_sel), .i_csr (i_csr), .o_csr (o_csr),
      .i_mepc_wen (i_mepc_wen), .i_mepc (i_mepc),
      .i_mtval_wen (i_mtval_wen), .i_mtval (i_mtval),
      .i_rreq (i_rreq), .o_rgnt (o_rgnt),
      .i_rs1_raddr (i_rs1_raddr), .o_rs1 (o_rs1),
      .i_rs2_raddr (i_rs2_raddr), .o_rs2 (o_rs2)
   );

   always #4 i_clk = ~i_clk;

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      // Taps 32, 22, 2, 1
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      int i;
      v = 32'd0;
      for (i = 0; i < n; i++) begin
         lfsr_q = lfsr_step(lfsr_q);
         v = {v[30:0], lfsr_q[0]};
      end
   endtask

   task automatic get_word(input logic [1:0] vsrc, output logic [31:0] w);
      case (vsrc)
         VS_ONES: w = 32'hffff_ffff;
         VS_ZERO: w = 32'h0000_0000;
         default: take_bits(`RF_DATA_W, w);
      endcase
   endtask

   // i_csr lands in mtvec on its select and in mscratch otherwise
   function automatic logic [1:0] csr_target(input logic [1:0] sel);
      return (sel == 2'd1) ? 2'd1 : 2'd0;
   endfunction

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] got);
      if (got !== exp) begin
         $display("Error %s expected %h got %h", name, exp, got);
         $display("TESTS FAILED");
         $fatal(1);
      end
   endtask

   task automatic add_row(input logic [1:0] op, input logic [3:0] mask, input logic [4:0] rd,
                          input logic [4:0] alt, input logic [4:0] rs1, input logic [4:0] rs2,
                          input logic [1:0] sel, input logic en, input logic [1:0] vsrc);
      if (nrows < NROWS) begin
         rows[nrows] = '{op, mask, rd, alt, rs1, rs2, sel, en, vsrc};
      end
      if (op != OP_RD && mask[3] && !gpr_seen[rd]) begin
         gpr_seen[rd] = 1'b1;
         wr_list.push_back(rd);
      end
      nrows++;
   endtask

   task automatic add_write(input logic [3:0] mask, input logic [4:0] rd,
                            input logic [1:0] sel, input logic [1:0] vsrc);
      add_row(OP_WR, mask, rd, 5'd0, 5'd0, 5'd0, sel, 1'b0, vsrc);
   endtask

   task automatic add_read(input logic [4:0] rs1, input logic [4:0] rs2,
                           input logic [1:0] sel, input logic en);
      add_row(OP_RD, 4'b0000, 5'd0, 5'd0, rs1, rs2, sel, en, VS_LFSR);
   endtask

   task automatic build_table();
      logic [31:0] v;
      logic [31:0] a;
      logic [31:0] b;
      int          i;
      int          ia;
      int          ib;
      add_write(4'b1000, 5'd1, 2'd0, VS_LFSR);
      add_write(4'b1000, 5'd2, 2'd0, VS_LFSR);
      add_write(4'b1000, 5'd5, 2'd0, VS_ONES);
      add_write(4'b1000, 5'd17, 2'd0, VS_LFSR);
      add_write(4'b1000, 5'd31, 2'd0, VS_ZERO);
      add_write(4'b1000, 5'd0, 2'd0, VS_LFSR);
      add_read(5'd1, 5'd2, 2'd0, 1'b0);
      add_read(5'd5, 5'd31, 2'd0, 1'b0);
      add_read(5'd17, 5'd17, 2'd0, 1'b0);
      add_read(5'd0, 5'd1, 2'd0, 1'b0);
      // mscratch and mtvec through i_csr, then the trap ports
      add_write(4'b0100, 5'd0, 2'd0, VS_LFSR);
      add_write(4'b0100, 5'd0, 2'd1, VS_LFSR);
      add_write(4'b0010, 5'd0, 2'd0, VS_LFSR);
      add_write(4'b0001, 5'd0, 2'd0, VS_LFSR);
      add_read(5'd2, 5'd5, 2'd0, 1'b1);
      add_read(5'd1, 5'd17, 2'd1, 1'b1);
      add_read(5'd31, 5'd0, 2'd2, 1'b1);
      add_read(5'd2, 5'd2, 2'd3, 1'b1);
      add_read(5'd5, 5'd1, 2'd1, 1'b0);
      add_write(4'b1111, 5'd9, 2'd0, VS_LFSR);
      add_read(5'd9, 5'd1, 2'd0, 1'b1);
      add_read(5'd9, 5'd9, 2'd2, 1'b1);
      add_read(5'd2, 5'd9, 2'd3, 1'b1);
      // Late enables aimed at x13, mepc and mtval
      add_write(4'b1000, 5'd13, 2'd0, VS_LFSR);
      add_row(OP_LATE, 4'b1000, 5'd12, 5'd13, 5'd0, 5'd0, 2'd0, 1'b0, VS_LFSR);
      add_read(5'd12, 5'd13, 2'd2, 1'b1);
      add_read(5'd13, 5'd12, 2'd3, 1'b1);
      for (i = 0; i < 20; i++) begin
         take_bits(2, v);
         take_bits(5, a);
         take_bits(5, b);
         if (!v[1]) begin
            ia = int'(a[4:0]) % wr_list.size();
            ib = int'(b[4:0]) % wr_list.size();
            take_bits(3, v);
            add_read(wr_list[ia], wr_list[ib], v[2:1], v[0]);
         end else if (v[0]) begin
            add_write(4'b1000, a[4:0], 2'd0, VS_LFSR);
         end else begin
            add_write((b[4:1] == 4'd0) ? 4'b1111 : b[4:1], a[4:0], {1'b0, b[0]}, VS_LFSR);
         end
      end
   endtask

   task automatic idle_cycles(input int n);
      int i;
      for (i = 0; i < n; i++) begin
         @(negedge i_clk);
         check_value("o_rgnt", 32'd0, {31'd0, o_rgnt});
         {i_rd_wen, i_csr_en, i_mepc_wen, i_mtval_wen, i_rreq} = 5'b00000;
         {i_rd, i_csr, i_mepc, i_mtval} = 4'b0000;
      end
   endtask

   // One bit per cycle, LSB first, enables only in the first cycle
   task automatic write_burst(input logic [3:0] mask, input logic [4:0] rd, input logic [4:0] alt,
                              input logic [1:0] sel, input logic late, input logic [31:0] wrd,
                              input logic [31:0] wc, input logic [31:0] wm, input logic [31:0] wt);
      int k;
      for (k = 0; k < `RF_DATA_W; k++) begin
         @(negedge i_clk);
         check_value("o_rgnt", 32'd0, {31'd0, o_rgnt});
         {i_rd, i_csr, i_mepc, i_mtval} = {wrd[k], wc[k], wm[k], wt[k]};
         i_csr_sel = sel;
         if (k == 0) begin
            {i_rd_wen, i_csr_en, i_mepc_wen, i_mtval_wen} = mask;
            i_rd_waddr = rd;
         end else if (late && k >= 8 && k < 16) begin
            {i_rd_wen, i_csr_en, i_mepc_wen, i_mtval_wen} = 4'b1011;
            i_rd_waddr = alt;
         end else begin
            {i_rd_wen, i_csr_en, i_mepc_wen, i_mtval_wen} = 4'b0000;
         end
      end
      // Leaves the RAM updated and the scheduler idle
      idle_cycles(9);
   endtask

   task automatic collect_bit(input int idx);
      got_rs1[idx] = o_rs1;
      got_rs2[idx] = o_rs2;
      got_csr[idx] = o_csr;
   endtask

   task automatic read_burst(input logic [4:0] rs1, input logic [4:0] rs2, input logic [1:0] sel,
                             input logic en, input logic [31:0] wb);
      int k;
      for (k = 0; k < `RF_DATA_W + 5; k++) begin
         @(negedge i_clk);
         check_value("o_rgnt", {31'd0, k == 4}, {31'd0, o_rgnt});
         if (k >= 5) begin
            collect_bit(k - 5);
         end
         i_rreq      = (k == 0);
         i_rs1_raddr = rs1;
         i_rs2_raddr = rs2;
         i_csr_sel   = sel;
         // Dropped before the write side goes idle again
         i_csr_en    = en && (k < `RF_DATA_W + 4);
         i_csr       = (k < `RF_DATA_W) ? wb[k] : 1'b0;
      end
      idle_cycles(2);
   endtask

   task automatic apply_row(input row_t row);
      logic [31:0] wrd;
      logic [31:0] wc;
      logic [31:0] wm;
      logic [31:0] wt;
      logic [31:0] wb;
      if (row.op == OP_RD) begin
         // CSR read also rewrites the target slot, so feed back its old word
         wb = row.csr_en ? csr[csr_target(row.sel)] : 32'd0;
         read_burst(row.rs1, row.rs2, row.sel, row.csr_en, wb);
         check_value("o_rs1", gpr[row.rs1], got_rs1);
         check_value("o_rs2", gpr[row.rs2], got_rs2);
         check_value("o_csr", row.csr_en ? csr[row.sel] : 32'd0, got_csr);
      end else begin
         get_word(row.vsrc, wrd);
         get_word(row.vsrc, wc);
         get_word(row.vsrc, wm);
         get_word(row.vsrc, wt);
         write_burst(row.mask, row.rd, row.alt, row.sel, row.op == OP_LATE, wrd, wc, wm, wt);
         if (row.mask[3]) gpr[row.rd] = wrd;
         if (row.mask[2]) csr[csr_target(row.sel)] = wc;
         if (row.mask[1]) csr[2] = wm;
         if (row.mask[0]) csr[3] = wt;
      end
   endtask

   initial begin
      repeat (NROWS * 50 + RST_CYCLES) @(posedge i_clk);
      $display("Timeout: the run did not finish within %0d cycles", NROWS * 50 + RST_CYCLES);
      $display("TESTS FAILED");
      $fatal(1);
   end

   initial begin
      i_clk = 1'b0;
      i_rst = 1'b1;
      {i_rd_wen, i_csr_en, i_mepc_wen, i_mtval_wen, i_rreq} = 5'b00000;
      {i_rd, i_csr, i_mepc, i_mtval} = 4'b0000;
      i_rd_waddr  = 5'd0;
      i_csr_sel   = 2'd0;
      i_rs1_raddr = 5'd0;
      i_rs2_raddr = 5'd0;
      lfsr_q   = 32'hc81a7d4a;
      nrows    = 0;
      gpr_seen = 32'd0;
      build_table();
      if (nrows != NROWS) begin
         $display("Stimulus table holds %0d rows instead of %0d", nrows, NROWS);
         $display("TESTS FAILED");
         $fatal(1);
      end
      for (r = 0; r < RST_CYCLES; r++) begin
         @(negedge i_clk);
         check_value("o_rgnt", 32'd0, {31'd0, o_rgnt});
      end
      i_rst = 1'b0;
      for (r = 0; r < NROWS; r++) begin
         apply_row(rows[r]);
      end
      $display("TESTS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// File: rtl/serial_rf.sv
`timescale 1ns/100ps
`default_nettype none

`include "serial_rf_cfg.svh"

module serial_rf (
   input  wire        i_clk,
   input  wire        i_rst,
   // rd write port
   input  wire        i_rd_wen,
   input  wire [4:0]  i_rd_waddr,
   input  wire        i_rd,
   // CSR access
   input  wire        i_csr_en,
   input  wire [1:0]  i_csr_sel,
   input  wire        i_csr,
   output logic       o_csr,
   // Trap registers
   input  wire        i_mepc_wen,
   input  wire        i_mepc,
   input  wire        i_mtval_wen,
   input  wire        i_mtval,
   // Read side
   input  wire        i_rreq,
   output logic       o_rgnt,
   input  wire [4:0]  i_rs1_raddr,
   output logic       o_rs1,
   input  wire [4:0]  i_rs2_raddr,
   output logic       o_rs2
);

   import serial_rf_pkg::*;

   logic                 wen;
   rf_addr_u             waddr;
   logic [`RF_NIB_W-1:0] wdata;
   rf_addr_u             raddr;
   logic [`RF_NIB_W-1:0] rdata;

   rf_write_sched u_wr (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_rd_wen    (i_rd_wen),
      .i_rd_waddr  (i_rd_waddr),
      .i_rd        (i_rd),
      .i_csr_en    (i_csr_en),
      .i_csr_sel   (i_csr_sel),
      .i_csr       (i_csr),
      .i_mepc_wen  (i_mepc_wen),
      .i_mepc      (i_mepc),
      .i_mtval_wen (i_mtval_wen),
      .i_mtval     (i_mtval),
      .o_wen       (wen),
      .o_waddr     (waddr),
      .o_wdata     (wdata)
   );

   rf_read_sched u_rd (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_rreq      (i_rreq),
      .i_rs1_raddr (i_rs1_raddr),
      .i_rs2_raddr (i_rs2_raddr),
      .i_csr_en    (i_csr_en),
      .i_csr_sel   (i_csr_sel),
      .i_rdata     (rdata),
      .o_raddr     (raddr),
      .o_rgnt      (o_rgnt),
      .o_rs1       (o_rs1),
      .o_rs2       (o_rs2),
      .o_csr       (o_csr)
   );

   rf_ram u_ram (
      .i_clk   (i_clk),
      .i_wen   (wen),
      .i_waddr (waddr),
      .i_wdata (wdata),
      .i_raddr (raddr),
      .o_rdata (rdata)
   );

endmodule

`default_nettype wire

// File: rtl/rf_read_sched.sv
`timescale 1ns/100ps
`default_nettype none

`include "serial_rf_cfg.svh"

module rf_read_sched (
   input  wire                           i_clk,
   input  wire                           i_rst,
   input  wire                           i_rreq,
   input  wire [4:0]                     i_rs1_raddr,
   input  wire [4:0]                     i_rs2_raddr,
   input  wire                           i_csr_en,
   input  wire [1:0]                     i_csr_sel,
   input  wire [`RF_NIB_W-1:0]           i_rdata,
   output serial_rf_pkg::rf_addr_u       o_raddr,
   output logic                          o_rgnt,
   output logic                          o_rs1,
   output logic                          o_rs2,
   output logic                          o_csr
);

   import serial_rf_pkg::*;

   // Read phases: rs1, rs2, csr, spare
   logic [3:0]                     phase;
   logic [$clog2(`RF_NIBBLES)-1:0] nib;
   logic [2:0]                     req_dly;
   logic [1:0]                     slot_r;
   logic [4:0]                     rs1_idx;
   logic [4:0]                     rs2_idx;

   // Lengths differ by one so all three streams leave together
   logic [`RF_NIB_W+1:0] rs1_sr;
   logic [`RF_NIB_W:0]   rs2_sr;
   logic [`RF_NIB_W-1:0] csr_sr;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         phase   <= 4'b0000;
         nib     <= '0;
         req_dly <= 3'b000;
         o_rgnt  <= 1'b0;
         slot_r  <= CSR_MSCRATCH;
      end else begin
         {o_rgnt, req_dly} <= {req_dly, i_rreq};
         if (i_rreq) begin
            phase  <= 4'b0001;
            nib    <= '0;
            slot_r <= i_csr_sel;
         end else if (phase[3]) begin
            nib   <= nib + 1'b1;
            phase <= (nib == `RF_NIBBLES-1) ? 4'b0000 : 4'b0001;
         end else begin
            phase <= {phase[2:0], 1'b0};
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rreq) begin
         rs1_idx <= i_rs1_raddr;
         rs2_idx <= i_rs2_raddr;
      end
      // RAM data arrives one phase after its address
      rs1_sr <= phase[1] ? {i_rdata, rs1_sr[2:1]} : {1'b0, rs1_sr[`RF_NIB_W+1:1]};
      rs2_sr <= phase[2] ? {i_rdata, rs2_sr[1]}   : {1'b0, rs2_sr[`RF_NIB_W:1]};
      csr_sr <= phase[3] ? i_rdata                : {1'b0, csr_sr[`RF_NIB_W-1:1]};
   end

   always_comb begin
      o_raddr = '0;
      if (phase[0] | phase[1]) begin
         o_raddr.gpr.region = 1'b0;
         o_raddr.gpr.idx    = phase[0] ? rs1_idx : rs2_idx;
         o_raddr.gpr.nib    = nib;
      end else begin
         o_raddr.csr.region = 1'b1;
         o_raddr.csr.zero   = 3'b000;
         o_raddr.csr.slot   = slot_r;
         o_raddr.csr.nib    = nib;
      end
   end

   assign o_rs1 = rs1_sr[0];
   assign o_rs2 = rs2_sr[0];
   assign o_csr = csr_sr[0] & i_csr_en;

   // Counters restart on a request, so requests must be spaced out
   a_rreq_spacing : assert property (
      @(posedge i_clk) disable iff (i_rst)
      i_rreq |=> !i_rreq [*(`RF_DATA_W+3)]
   ) else $error("read request inside previous read window");

endmodule

`default_nettype wire

// File: rtl/rf_write_sched.sv
`timescale 1ns/100ps
`default_nettype none

`include "serial_rf_cfg.svh"

module rf_write_sched (
   input  wire                           i_clk,
   input  wire                           i_rst,
   input  wire                           i_rd_wen,
   input  wire [4:0]                     i_rd_waddr,
   input  wire                           i_rd,
   input  wire                           i_csr_en,
   input  wire [1:0]                     i_csr_sel,
   input  wire                           i_csr,
   input  wire                           i_mepc_wen,
   input  wire                           i_mepc,
   input  wire                           i_mtval_wen,
   input  wire                           i_mtval,
   output logic                          o_wen,
   output serial_rf_pkg::rf_addr_u       o_waddr,
   output logic [`RF_NIB_W-1:0]          o_wdata
);

   import serial_rf_pkg::*;

   // Phase order: mepc, mtval, csr, rd
   logic [3:0]                     phase;
   logic [$clog2(`RF_NIBBLES)-1:0] nib;
   logic                           fill;
   logic [3:0]                     en_r;
   logic [4:0]                     rd_idx;
   logic [1:0]                     slot_r;
   logic                           start;

   // Staggered so each nibble is whole when its phase comes round
   logic [`RF_NIB_W:0]   mepc_sr;
   logic [`RF_NIB_W+1:0] mtval_sr;
   logic [`RF_NIB_W+2:0] csr_sr;
   logic [`RF_NIB_W+3:0] rd_sr;

   assign start = (phase == 4'b0000) &
                  (i_rd_wen | i_csr_en | i_mepc_wen | i_mtval_wen);

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         phase <= 4'b0000;
         nib   <= '0;
         fill  <= 1'b0;
         en_r  <= 4'b0000;
      end else if (start) begin
         phase <= 4'b0001;
         nib   <= '0;
         fill  <= 1'b1;
         en_r  <= {i_rd_wen, i_csr_en, i_mtval_wen, i_mepc_wen};
      end else if (phase[3]) begin
         if (fill) begin
            // Warm-up lap done, real writes start with nibble 0
            fill  <= 1'b0;
            phase <= 4'b0001;
         end else if (nib == `RF_NIBBLES-1) begin
            phase <= 4'b0000;
            nib   <= '0;
         end else begin
            phase <= 4'b0001;
            nib   <= nib + 1'b1;
         end
      end else begin
         phase <= {phase[2:0], 1'b0};
      end
   end

   always_ff @(posedge i_clk) begin
      if (start) begin
         rd_idx <= i_rd_waddr;
         // mepc and mtval have their own ports
         slot_r <= (i_csr_sel == CSR_MTVEC) ? CSR_MTVEC : CSR_MSCRATCH;
      end
      mepc_sr  <= {i_mepc, mepc_sr[`RF_NIB_W:1]};
      mtval_sr <= {i_mtval, mtval_sr[`RF_NIB_W+1:1]};
      csr_sr   <= {i_csr, csr_sr[`RF_NIB_W+2:1]};
      rd_sr    <= {i_rd, rd_sr[`RF_NIB_W+3:1]};
   end

   always_comb begin
      o_waddr = '0;
      if (phase[3]) begin
         o_waddr.gpr.region = 1'b0;
         o_waddr.gpr.idx    = rd_idx;
         o_waddr.gpr.nib    = nib;
      end else begin
         o_waddr.csr.region = 1'b1;
         o_waddr.csr.zero   = 3'b000;
         o_waddr.csr.slot   = phase[0] ? CSR_MEPC  :
                              phase[1] ? CSR_MTVAL : slot_r;
         o_waddr.csr.nib    = nib;
      end
   end

   assign o_wdata = phase[0] ? mepc_sr[`RF_NIB_W-1:0]  :
                    phase[1] ? mtval_sr[`RF_NIB_W-1:0] :
                    phase[2] ? csr_sr[`RF_NIB_W-1:0]   : rd_sr[`RF_NIB_W-1:0];

   assign o_wen = !fill & |(en_r & phase);

   a_waddr_known : assert property (
      @(posedge i_clk) disable iff (i_rst)
      o_wen |-> !$isunknown(o_waddr)
   ) else $error("write issued with unknown address");

   // Last rd nibble lands 36 cycles in, idle on the next one
   a_burst_len : assert property (
      @(posedge i_clk) disable iff (i_rst)
      start |-> ##(`RF_DATA_W+5) (phase == 4'b0000)
   ) else $error("write burst did not finish on time");

endmodule

`default_nettype wire

// File: rtl/rf_ram.sv
`timescale 1ns/100ps
`default_nettype none

`include "serial_rf_cfg.svh"

module rf_ram (
   input  wire                          i_clk,
   input  wire                          i_wen,
   input  wire serial_rf_pkg::rf_addr_u i_waddr,
   input  wire [`RF_NIB_W-1:0]          i_wdata,
   input  wire serial_rf_pkg::rf_addr_u i_raddr,
   output logic [`RF_NIB_W-1:0]         o_rdata
);

   import serial_rf_pkg::*;

   logic [`RF_NIB_W-1:0]  mem [0:`RF_DEPTH-1];
   logic [`RF_ADDR_W-1:0] wa;
   logic [`RF_ADDR_W-1:0] ra;

   // Flat word index from either address view
   assign wa = i_waddr;
   assign ra = i_raddr;

   // Read sees the old word on a same-address collision
   always_ff @(posedge i_clk) begin
      if (i_wen) begin
         mem[wa] <= i_wdata;
      end
      o_rdata <= mem[ra];
   end

   // Both schedulers must keep the unused CSR-view bits clear
   a_waddr_csr_zero : assert property (
      @(posedge i_clk)
      (i_wen && i_waddr.csr.region) |-> (i_waddr.csr.zero == 3'b000)
   ) else $error("write to CSR region with nonzero unused bits");

   a_raddr_csr_zero : assert property (
      @(posedge i_clk)
      i_raddr.csr.region |-> (i_raddr.csr.zero == 3'b000)
   ) else $error("read from CSR region with nonzero unused bits");

endmodule

`default_nettype wire

// File: rtl/serial_rf_pkg.sv
`default_nettype none

`include "serial_rf_cfg.svh"

package serial_rf_pkg;

   // General purpose registers, region bit low
   typedef struct packed {
      logic                    region;
      logic [`RF_ADDR_W-5:0]   idx;
      logic [2:0]              nib;
   } rf_gpr_addr_t;

   // CSR storage, region bit high and the middle bits unused
   typedef struct packed {
      logic       region;
      logic [2:0] zero;
      logic [1:0] slot;
      logic [2:0] nib;
   } rf_csr_addr_t;

   typedef union packed {
      rf_gpr_addr_t gpr;
      rf_csr_addr_t csr;
   } rf_addr_u;

   // CSR slots in the upper region
   localparam logic [1:0] CSR_MSCRATCH = 2'd0;
   localparam logic [1:0] CSR_MTVEC    = 2'd1;
   localparam logic [1:0] CSR_MEPC     = 2'd2;
   localparam logic [1:0] CSR_MTVAL    = 2'd3;

endpackage

`default_nettype wire

// File: rtl/serial_rf_cfg.svh
`ifndef SERIAL_RF_CFG_SVH
`define SERIAL_RF_CFG_SVH

// Architectural register width
`define RF_DATA_W 32

// RAM word width, one nibble per access
`define RF_NIB_W 4

// Nibbles that make up one register
`define RF_NIBBLES 8

// Region bit + 5-bit index + 3-bit nibble
`define RF_ADDR_W 9

// Words in the register RAM
`define RF_DEPTH 512

`endif
